// File: acq_defs.svh
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// core sizing
`define NUM_CHAN            4
`define CMD_FIFO_DEPTH      4
`define SAMPLE_FIFO_DEPTH   8
`define FIFO_ALMOST_MARGIN  1   // distance of the almost flags from full / empty

// ------------------------------------------------------------
// ebi register map
`define EBI_ADDR_STATUS       0
`define EBI_ADDR_CMD_W1       1   // chan, count
`define EBI_ADDR_CMD_W2       2   // start_time high half
`define EBI_ADDR_CMD_W3       3   // start_time low half
`define EBI_ADDR_CMD_W4       4   // first value
`define EBI_ADDR_CMD_W5       5   // period, pushes the command
`define EBI_ADDR_NEXT_SAMPLE  6
`define EBI_ADDR_RESET_TIME   7
`define EBI_ADDR_RUN_TIME     8
`define EBI_ADDR_TIME_L       9
`define EBI_ADDR_TIME_H       10

`define EBI_EMPTY_READ  16'hDEAD  // next sample read with nothing queued

`endif

// File: acq_pkg.sv
package acq_pkg;

  // one burst command as the timers see it
  typedef struct packed {
    logic [7:0]  chan;        // target timer
    logic [7:0]  count;       // samples in the burst, 0 is none
    logic [31:0] start_time;  // global time of first sample
    logic [15:0] value;       // first sample value
    logic [15:0] period;      // cycles between samples, 0 acts as 1
  } cmd_fields_t;

  // same 80 bits, seen as the five bus words or as fields
  // word 1 sits in the top 16 bits
  typedef union packed {
    logic [1:5][15:0] words;
    cmd_fields_t      f;
  } cmd_u;

  typedef struct packed {
    logic almost_full;
    logic full;
    logic almost_empty;
    logic empty;
  } fifo_flags_t;

  // ------------------------------------------------------------
  // status word as read at the STATUS address
  typedef struct packed {
    fifo_flags_t cmd_flags;
    fifo_flags_t sample_flags;
    logic [7:0]  rsvd;        // always zero
  } status_t;

endpackage

// File: sync_fifo.sv
`timescale 1ns/100ps
`include "acq_defs.svh"

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en,
  input  logic [WIDTH-1:0]     wr_data,
  input  logic                 rd_en,
  output logic [WIDTH-1:0]     rd_data,
  output acq_pkg::fifo_flags_t flags
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en && !flags.full;   // write into a full fifo is dropped
  assign do_rd = rd_en && !flags.empty;

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  assign rd_data            = mem[rd_ptr];  // show-ahead head
  assign flags.full         = (count == CW'(DEPTH));
  assign flags.empty        = (count == '0);
  assign flags.almost_full  = (count >= CW'(DEPTH - `FIFO_ALMOST_MARGIN));
  assign flags.almost_empty = (count <= CW'(`FIFO_ALMOST_MARGIN));

endmodule

// File: ebi_bridge.sv
`timescale 1ns/100ps
`include "acq_defs.svh"

module ebi_bridge (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [15:0]          data_in,
  output logic [15:0]          data_out,
  input  logic [18:0]          addr,
  input  logic                 rd,
  input  logic                 wr,
  input  logic                 cs,
  output logic [31:0]          global_clock,
  output logic                 irq,
  output acq_pkg::cmd_u        cmd_word,
  output logic                 cmd_push,
  input  acq_pkg::fifo_flags_t cmd_flags,
  input  logic [15:0]          sample_head,
  input  acq_pkg::fifo_flags_t sample_flags,
  output logic                 sample_pop
);

  // one-hot transaction states
  localparam logic [4:0] ST_FETCH           = 5'b00001;
  localparam logic [4:0] ST_CMD_WAIT        = 5'b00010;
  localparam logic [4:0] ST_TIME_RESET_WAIT = 5'b00100;
  localparam logic [4:0] ST_TIME_RUN_WAIT   = 5'b01000;
  localparam logic [4:0] ST_SAMPLE_WAIT     = 5'b10000;

  localparam acq_pkg::status_t STATUS_RST = 16'h3300;  // both fifos empty

  logic             wr_sel;
  logic             rd_sel;
  logic             wr_d;
  logic             wr_dd;
  logic             rd_d;
  logic             rd_dd;
  logic             wr_done;
  logic             rd_done;
  logic [4:0]       state;
  logic [4:0]       state_nxt;
  logic             push_now;
  logic             pop_now;
  logic             clr_now;
  logic             run_now;
  logic             time_run;
  logic             sample_hit;    // last sample read returned real data
  acq_pkg::cmd_u    cmd_q;
  acq_pkg::status_t status_q;
  acq_pkg::status_t status_seen;   // status at the last STATUS read

  assign wr_sel   = cs && wr;
  assign rd_sel   = cs && rd;
  assign cmd_word = cmd_q;

  // ------------------------------------------------------------
  // strobe falling edges, two stages
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_d  <= 1'b0;
      wr_dd <= 1'b0;
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
    end else begin
      wr_d  <= wr_sel;
      wr_dd <= wr_d;
      rd_d  <= rd_sel;
      rd_dd <= rd_d;
    end
  end

  assign wr_done = wr_dd && !wr_d;
  assign rd_done = rd_dd && !rd_d;

  // ------------------------------------------------------------
  // transaction fsm
  always_comb begin
    state_nxt = state;
    push_now  = 1'b0;
    pop_now   = 1'b0;
    clr_now   = 1'b0;
    run_now   = 1'b0;
    case (state)
      ST_FETCH: begin
        if (wr_sel) begin
          if (addr == `EBI_ADDR_CMD_W5) state_nxt = ST_CMD_WAIT;
          else if (addr == `EBI_ADDR_RESET_TIME) state_nxt = ST_TIME_RESET_WAIT;
          else if (addr == `EBI_ADDR_RUN_TIME) state_nxt = ST_TIME_RUN_WAIT;
        end else if (rd_sel && addr == `EBI_ADDR_NEXT_SAMPLE) begin
          state_nxt = ST_SAMPLE_WAIT;
        end
      end
      ST_CMD_WAIT: begin
        if (wr_done) begin
          state_nxt = ST_FETCH;
          push_now  = 1'b1;
        end
      end
      ST_TIME_RESET_WAIT: begin
        if (wr_done) begin
          state_nxt = ST_FETCH;
          clr_now   = 1'b1;
        end
      end
      ST_TIME_RUN_WAIT: begin
        if (wr_done) begin
          state_nxt = ST_FETCH;
          run_now   = 1'b1;
        end
      end
      ST_SAMPLE_WAIT: begin
        if (rd_done) begin
          state_nxt = ST_FETCH;
          pop_now   = sample_hit;  // nothing to pop after an empty read
        end
      end
      default: state_nxt = ST_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_FETCH;
      cmd_push   <= 1'b0;
      sample_pop <= 1'b0;
    end else begin
      state      <= state_nxt;
      cmd_push   <= push_now;
      sample_pop <= pop_now;
    end
  end

  // command words, latched every cycle of the write
  always_ff @(posedge clk) begin
    if (wr_sel) begin
      case (addr)
        `EBI_ADDR_CMD_W1: cmd_q.words[1] <= data_in;
        `EBI_ADDR_CMD_W2: cmd_q.words[2] <= data_in;
        `EBI_ADDR_CMD_W3: cmd_q.words[3] <= data_in;
        `EBI_ADDR_CMD_W4: cmd_q.words[4] <= data_in;
        `EBI_ADDR_CMD_W5: cmd_q.words[5] <= data_in;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // read data, status and irq
  always_ff @(posedge clk) begin
    if (rst) begin
      data_out    <= 16'h0000;
      sample_hit  <= 1'b0;
      status_q    <= STATUS_RST;
      status_seen <= STATUS_RST;
      irq         <= 1'b0;
    end else begin
      status_q <= '{cmd_flags: cmd_flags, sample_flags: sample_flags, rsvd: 8'h00};
      irq      <= (status_q != status_seen);  // held until status is read
      if (rd_sel) begin
        case (addr)
          `EBI_ADDR_STATUS: begin
            data_out    <= status_q;
            status_seen <= status_q;
          end
          `EBI_ADDR_NEXT_SAMPLE: begin
            data_out   <= sample_flags.empty ? `EBI_EMPTY_READ : sample_head;
            sample_hit <= !sample_flags.empty;
          end
          `EBI_ADDR_TIME_L: data_out <= global_clock[15:0];
          `EBI_ADDR_TIME_H: data_out <= global_clock[31:16];
          default: ;
        endcase
      end
    end
  end

  // global time, a reset also stops it
  always_ff @(posedge clk) begin
    if (rst) begin
      global_clock <= 32'd0;
      time_run     <= 1'b0;
    end else if (clr_now) begin
      global_clock <= 32'd0;
      time_run     <= 1'b0;
    end else begin
      if (time_run) global_clock <= global_clock + 32'd1;
      if (run_now) time_run <= 1'b1;
    end
  end

endmodule

// File: cmd_dispatch.sv
`timescale 1ns/100ps
`include "acq_defs.svh"

module cmd_dispatch (
  input  logic                  clk,
  input  logic                  rst,
  input  acq_pkg::cmd_u         cmd_head,
  input  acq_pkg::fifo_flags_t  cmd_flags,
  output logic                  cmd_pop,
  output acq_pkg::cmd_fields_t  chan_cmd,
  output logic [`NUM_CHAN-1:0]  chan_load,
  input  logic [`NUM_CHAN-1:0]  chan_busy
);

  localparam int CHAN_W = (`NUM_CHAN > 1) ? $clog2(`NUM_CHAN) : 1;

  logic              in_range;
  logic [CHAN_W-1:0] idx;
  logic              issue;

  assign in_range = (cmd_head.f.chan < `NUM_CHAN);
  assign idx      = cmd_head.f.chan[CHAN_W-1:0];
  // head stays valid for one more cycle after a pop, so skip that cycle
  assign issue    = !cmd_flags.empty && !cmd_pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_pop   <= 1'b0;
      chan_load <= '0;
    end else begin
      cmd_pop   <= 1'b0;
      chan_load <= '0;
      if (issue) begin
        if (!in_range) begin
          cmd_pop <= 1'b1;  // bad channel, drop it
        end else if (!chan_busy[idx]) begin
          cmd_pop        <= 1'b1;
          chan_load[idx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue && in_range) chan_cmd <= cmd_head.f;
  end

endmodule

// File: chan_timer.sv
`timescale 1ns/100ps

module chan_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  acq_pkg::cmd_fields_t cmd,
  input  logic [31:0]          global_clock,
  output logic                 busy,
  output logic                 req,
  output logic [15:0]          sample,
  input  logic                 grant
);

  logic [7:0]  remaining;  // samples still to emit
  logic [31:0] due;        // global time of next sample
  logic [15:0] period_q;
  logic        reached;

  // wrap-safe compare, a start time in the past fires at once
  assign reached = ($signed(global_clock - due) >= 0);
  assign req     = busy && reached;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (load) begin
      busy <= (cmd.count != 8'd0);
    end else if (grant && remaining == 8'd1) begin
      busy <= 1'b0;  // last sample taken
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      remaining <= cmd.count;
      due       <= cmd.start_time;
      sample    <= cmd.value;
      period_q  <= (cmd.period == 16'd0) ? 16'd1 : cmd.period;
    end else if (grant) begin
      remaining <= remaining - 8'd1;
      due       <= due + {16'h0000, period_q};
      sample    <= sample + 16'd1;
    end
  end

endmodule

// File: sample_merge.sv
`timescale 1ns/100ps
`include "acq_defs.svh"

module sample_merge (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`NUM_CHAN-1:0]        req,
  input  logic [`NUM_CHAN-1:0][15:0]  samples,
  input  acq_pkg::fifo_flags_t        fifo_flags,
  output logic [`NUM_CHAN-1:0]        grant,
  output logic                        push,
  output logic [15:0]                 push_data
);

  logic        stall;
  logic        found;
  logic [15:0] sel_data;

  // a push still in flight takes the last free slot
  assign stall = fifo_flags.full || (push && fifo_flags.almost_full);

  // lowest index wins
  always_comb begin
    found    = 1'b0;
    grant    = '0;
    sel_data = samples[0];
    for (int i = 0; i < `NUM_CHAN; i++) begin
      if (req[i] && !found && !stall) begin
        grant[i] = 1'b1;
        sel_data = samples[i];
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) push <= 1'b0;
    else push <= |grant;
  end

  always_ff @(posedge clk) begin
    if (|grant) push_data <= sel_data;
  end

endmodule

// File: acq_top.sv
`timescale 1ns/100ps
`include "acq_defs.svh"

module acq_top (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] data_in,
  output logic [15:0] data_out,
  input  logic [18:0] addr,
  input  logic        rd,
  input  logic        wr,
  input  logic        cs,
  output logic [31:0] global_clock,
  output logic        irq
);

  acq_pkg::cmd_u               cmd_word;
  acq_pkg::cmd_u               cmd_head;
  logic                        cmd_push;
  logic                        cmd_pop;
  acq_pkg::fifo_flags_t        cmd_flags;
  acq_pkg::fifo_flags_t        sample_flags;
  logic [15:0]                 sample_head;
  logic                        sample_pop;
  logic                        sample_push;
  logic [15:0]                 sample_data;
  acq_pkg::cmd_fields_t        chan_cmd;
  logic [`NUM_CHAN-1:0]        chan_load;
  logic [`NUM_CHAN-1:0]        chan_busy;
  logic [`NUM_CHAN-1:0]        chan_req;
  logic [`NUM_CHAN-1:0]        chan_grant;
  logic [`NUM_CHAN-1:0][15:0]  chan_sample;

  ebi_bridge u_ebi_bridge (
    .clk(clk), .rst(rst),
    .data_in(data_in), .data_out(data_out), .addr(addr),
    .rd(rd), .wr(wr), .cs(cs),
    .global_clock(global_clock), .irq(irq),
    .cmd_word(cmd_word), .cmd_push(cmd_push), .cmd_flags(cmd_flags),
    .sample_head(sample_head), .sample_flags(sample_flags), .sample_pop(sample_pop)
  );

  // ------------------------------------------------------------
  // command path
  sync_fifo #(.WIDTH($bits(acq_pkg::cmd_u)), .DEPTH(`CMD_FIFO_DEPTH)) u_cmd_fifo (
    .clk(clk), .rst(rst),
    .wr_en(cmd_push), .wr_data(cmd_word),
    .rd_en(cmd_pop), .rd_data(cmd_head), .flags(cmd_flags)
  );

  cmd_dispatch u_cmd_dispatch (
    .clk(clk), .rst(rst),
    .cmd_head(cmd_head), .cmd_flags(cmd_flags), .cmd_pop(cmd_pop),
    .chan_cmd(chan_cmd), .chan_load(chan_load), .chan_busy(chan_busy)
  );

  for (genvar i = 0; i < `NUM_CHAN; i++) begin : g_chan
    chan_timer u_chan_timer (
      .clk(clk), .rst(rst),
      .load(chan_load[i]), .cmd(chan_cmd), .global_clock(global_clock),
      .busy(chan_busy[i]), .req(chan_req[i]), .sample(chan_sample[i]),
      .grant(chan_grant[i])
    );
  end

  // ------------------------------------------------------------
  // sample path
  sample_merge u_sample_merge (
    .clk(clk), .rst(rst),
    .req(chan_req), .samples(chan_sample), .fifo_flags(sample_flags),
    .grant(chan_grant), .push(sample_push), .push_data(sample_data)
  );

  sync_fifo #(.WIDTH(16), .DEPTH(`SAMPLE_FIFO_DEPTH)) u_sample_fifo (
    .clk(clk), .rst(rst),
    .wr_en(sample_push), .wr_data(sample_data),
    .rd_en(sample_pop), .rd_data(sample_head), .flags(sample_flags)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int PERIOD     = 100,  // ns
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // released on a falling edge
  end

endmodule

// File: tb_acq_top.sv
`timescale 1ns/100ps
`include "acq_defs.svh"

module tb_acq_top;

  localparam logic [2:0] K_WRITE = 3'd0;  // bus write
  localparam logic [2:0] K_READ  = 3'd1;  // bus read compared with exp
  localparam logic [2:0] K_RISE  = 3'd2;  // bus read above the previous read
  localparam logic [2:0] K_WAIT  = 3'd3;  // poll TIME_L until it reaches exp
  localparam logic [2:0] K_IRQ   = 3'd4;  // compare irq with exp[0]
  localparam logic [2:0] K_CLOCK = 3'd5;  // compare global_clock with exp

  localparam logic [3:0] FLAGS_EMPTY = 4'b0011;  // almost_empty and empty
  localparam logic [3:0] FLAGS_FULL  = 4'b1100;  // almost_full and full

  typedef struct packed {
    logic [2:0]  kind;
    logic [18:0] addr;
    logic [15:0] data;
    logic [15:0] exp;
  } step_t;

  logic        clk;
  logic        rst;
  logic [15:0] data_in;
  logic [15:0] data_out;
  logic [18:0] addr;
  logic        rd;
  logic        wr;
  logic        cs;
  logic [31:0] global_clock;
  logic        irq;

  step_t       steps [128];
  string       names [128];
  int          n_steps;
  int          errors;
  int          cycles;
  int          limit;
  logic [15:0] last_read;

  tb_clk_gen #(.PERIOD(100), .RST_CYCLES(3)) u_clk_gen (.clk(clk), .rst(rst));

  acq_top u_acq_top (
    .clk(clk), .rst(rst),
    .data_in(data_in), .data_out(data_out), .addr(addr),
    .rd(rd), .wr(wr), .cs(cs),
    .global_clock(global_clock), .irq(irq)
  );

  // ------------------------------------------------------------
  // table construction
  function automatic logic [15:0] status_of(input logic [3:0] cmd_f, input logic [3:0] smp_f);
    return {cmd_f, smp_f, 8'h00};
  endfunction

  task automatic add_step(input logic [2:0] kind, input int a, input logic [15:0] d,
                          input logic [15:0] e, input string name);
    steps[n_steps].kind = kind;
    steps[n_steps].addr = a[18:0];
    steps[n_steps].data = d;
    steps[n_steps].exp  = e;
    names[n_steps]      = name;
    n_steps++;
  endtask

  // word 1 carries chan and count
  task automatic add_cmd(input logic [7:0] chan, input logic [7:0] count,
                         input logic [31:0] start, input logic [15:0] value,
                         input logic [15:0] period, input string name);
    add_step(K_WRITE, `EBI_ADDR_CMD_W1, {chan, count}, 16'h0, name);
    add_step(K_WRITE, `EBI_ADDR_CMD_W2, start[31:16], 16'h0, name);
    add_step(K_WRITE, `EBI_ADDR_CMD_W3, start[15:0], 16'h0, name);
    add_step(K_WRITE, `EBI_ADDR_CMD_W4, value, 16'h0, name);
    add_step(K_WRITE, `EBI_ADDR_CMD_W5, period, 16'h0, name);
  endtask

  task automatic build_table();
    // reset state
    add_step(K_READ, `EBI_ADDR_STATUS, 0, status_of(FLAGS_EMPTY, FLAGS_EMPTY), "reset_status");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, `EBI_EMPTY_READ, "reset_empty_read");
    add_step(K_READ, `EBI_ADDR_TIME_L, 0, 16'h0, "reset_time_l");
    add_step(K_READ, `EBI_ADDR_TIME_H, 0, 16'h0, "reset_time_h");
    add_step(K_CLOCK, 0, 0, 16'h0, "reset_global_clock");
    add_step(K_IRQ, 0, 0, 16'h0, "reset_irq_low");
    // time counter run and stop
    add_step(K_WRITE, `EBI_ADDR_RUN_TIME, 0, 16'h0, "run_time");
    add_step(K_RISE, `EBI_ADDR_TIME_L, 0, 16'h0, "time_rising_1");
    add_step(K_RISE, `EBI_ADDR_TIME_L, 0, 16'h0, "time_rising_2");
    add_step(K_WRITE, `EBI_ADDR_RESET_TIME, 0, 16'h0, "reset_time");
    add_step(K_READ, `EBI_ADDR_TIME_L, 0, 16'h0, "time_stopped_1");
    add_step(K_READ, `EBI_ADDR_TIME_L, 0, 16'h0, "time_stopped_2");
    add_step(K_CLOCK, 0, 0, 16'h0, "stopped_global_clock");
    // single sample on timer 0 while time is stopped
    add_cmd(8'd0, 8'd1, 32'd100, 16'h1234, 16'd1, "single_cmd");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, `EBI_EMPTY_READ, "single_not_yet");
    add_step(K_WRITE, `EBI_ADDR_RUN_TIME, 0, 16'h0, "single_run");
    add_step(K_WAIT, 0, 0, 16'd120, "single_wait");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, 16'h1234, "single_sample");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, `EBI_EMPTY_READ, "single_drained");
    // burst of 4 with period 10
    add_step(K_WRITE, `EBI_ADDR_RESET_TIME, 0, 16'h0, "burst4_reset_time");
    add_cmd(8'd0, 8'd4, 32'd50, 16'h0100, 16'd10, "burst4_cmd");
    add_step(K_WRITE, `EBI_ADDR_RUN_TIME, 0, 16'h0, "burst4_run");
    add_step(K_WAIT, 0, 0, 16'd110, "burst4_wait");
    for (int k = 0; k < 4; k++) begin
      add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, 16'h0100 + 16'(k),
               $sformatf("burst4_sample_%0d", k));
    end
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, `EBI_EMPTY_READ, "burst4_drained");
    // two timers with the later start written first
    add_step(K_WRITE, `EBI_ADDR_RESET_TIME, 0, 16'h0, "order_reset_time");
    add_cmd(8'd2, 8'd1, 32'd300, 16'h2000, 16'd1, "order_cmd_t2");
    add_cmd(8'd1, 8'd1, 32'd150, 16'h1000, 16'd1, "order_cmd_t1");
    add_step(K_WRITE, `EBI_ADDR_RUN_TIME, 0, 16'h0, "order_run");
    add_step(K_WAIT, 0, 0, 16'd320, "order_wait");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, 16'h1000, "order_first");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, 16'h2000, "order_second");
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, `EBI_EMPTY_READ, "order_drained");
    // back-pressure with 12 samples into a fifo of 8
    add_step(K_WRITE, `EBI_ADDR_RESET_TIME, 0, 16'h0, "bp_reset_time");
    add_cmd(8'd3, 8'd12, 32'd20, 16'h3000, 16'd2, "bp_cmd");
    add_step(K_READ, `EBI_ADDR_STATUS, 0, status_of(FLAGS_EMPTY, FLAGS_EMPTY), "bp_status_idle");
    add_step(K_IRQ, 0, 0, 16'h0, "bp_irq_idle");
    add_step(K_WRITE, `EBI_ADDR_RUN_TIME, 0, 16'h0, "bp_run");
    add_step(K_WAIT, 0, 0, 16'd80, "bp_wait");
    add_step(K_IRQ, 0, 0, 16'h1, "bp_irq_full");
    add_step(K_READ, `EBI_ADDR_STATUS, 0, status_of(FLAGS_EMPTY, FLAGS_FULL), "bp_status_full");
    add_step(K_IRQ, 0, 0, 16'h0, "bp_irq_cleared");
    for (int k = 0; k < 12; k++) begin
      add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, 16'h3000 + 16'(k),
               $sformatf("bp_sample_%0d", k));
    end
    add_step(K_READ, `EBI_ADDR_NEXT_SAMPLE, 0, `EBI_EMPTY_READ, "bp_drained");
  endtask

  // each bus step takes 3 strobe and 4 idle cycles
  // a wait adds its target time
  function automatic int cycle_budget();
    int total;
    total = 10;  // reset
    for (int i = 0; i < n_steps; i++) begin
      case (steps[i].kind)
        K_IRQ:   total += 1;
        K_CLOCK: total += 1;
        K_WAIT:  total += int'(steps[i].exp) + 7;
        default: total += 7;
      endcase
    end
    return 2 * total;
  endfunction

  // ------------------------------------------------------------
  // bus tasks entered and left on a falling edge
  task automatic bus_write(input logic [18:0] a, input logic [15:0] d);
    addr    = a;
    data_in = d;
    cs      = 1'b1;
    wr      = 1'b1;
    repeat (3) @(negedge clk);
    cs = 1'b0;
    wr = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic bus_read(input logic [18:0] a, output logic [15:0] d);
    addr = a;
    cs   = 1'b1;
    rd   = 1'b1;
    repeat (3) @(negedge clk);
    cs = 1'b0;
    rd = 1'b0;
    repeat (4) @(negedge clk);
    d         = data_out;  // held since the last read cycle
    last_read = data_out;
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic run_step(input int i);
    step_t       s;
    logic [15:0] act;
    logic [15:0] prev;
    s = steps[i];
    case (s.kind)
      K_WRITE: bus_write(s.addr, s.data);
      K_READ: begin
        bus_read(s.addr, act);
        check_value(names[i], s.exp, act);
      end
      K_RISE: begin
        prev = last_read;
        bus_read(s.addr, act);
        assert (act > prev) else begin
          errors++;
          $display("MISMATCH %s: expected above %h, actual %h", names[i], prev, act);
        end
      end
      K_WAIT: begin
        bus_read(`EBI_ADDR_TIME_L, act);
        while (act < s.exp) bus_read(`EBI_ADDR_TIME_L, act);
        assert (global_clock >= {16'h0000, s.exp}) else begin
          errors++;
          $display("ERROR: %s global_clock %0d is still below the wait target %0d",
                   names[i], global_clock, s.exp);
        end
      end
      K_CLOCK: begin
        assert (global_clock === {16'h0000, s.exp}) else begin
          errors++;
          $display("MISMATCH %s: expected %h, actual %h", names[i], {16'h0000, s.exp},
                   global_clock);
        end
        @(negedge clk);
      end
      default: begin
        check_value(names[i], s.exp, {15'h0000, irq});
        @(negedge clk);
      end
    endcase
  endtask

  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("ERROR: run stopped after %0d cycles before the step table was done", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    cs        = 1'b0;
    rd        = 1'b0;
    wr        = 1'b0;
    addr      = '0;
    data_in   = '0;
    n_steps   = 0;
    errors    = 0;
    last_read = '0;
    build_table();
    limit = cycle_budget();
    wait (!rst);
    @(negedge clk);
    for (int i = 0; i < n_steps; i++) run_step(i);
    $display("tb_acq_top: %0d errors over %0d steps", errors, n_steps);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
acq_pkg.sv
sync_fifo.sv
ebi_bridge.sv
cmd_dispatch.sv
chan_timer.sv
sample_merge.sv
acq_top.sv
tb_clk_gen.sv
tb_acq_top.sv
